// ==== source/isa_pkg.sv ====
package isa_pkg;

   ////////////////////////////////////////
   // core widths

   localparam int CODE_AW   = 8;   // code address bits
   localparam int REG_COUNT = 8;   // r0 to r7

   typedef logic [CODE_AW-1:0] code_addr_t;
   typedef logic [7:0]         byte_t;

   ////////////////////////////////////////
   // opcodes, full byte

   localparam byte_t op_ljmp        = 8'h02;   // ljmp addr16
   localparam byte_t op_add_a_imm   = 8'h24;
   localparam byte_t op_jz          = 8'h60;
   localparam byte_t op_xrl_a_imm   = 8'h64;
   localparam byte_t op_jnz         = 8'h70;
   localparam byte_t op_mov_a_imm   = 8'h74;
   localparam byte_t op_sjmp        = 8'h80;
   localparam byte_t op_mov_dptr    = 8'h90;   // mov dptr,#imm16
   localparam byte_t op_subb_a_imm  = 8'h94;
   localparam byte_t op_clr_c       = 8'hC3;
   localparam byte_t op_movx_a_dptr = 8'hE0;
   localparam byte_t op_clr_a       = 8'hE4;
   localparam byte_t op_movx_dptr_a = 8'hF0;

   // register forms, low 3 bits pick rn
   localparam logic [4:0] op5_inc_r   = 5'h01;   // 08..0f
   localparam logic [4:0] op5_add_a_r = 5'h05;   // 28..2f
   localparam logic [4:0] op5_mov_a_r = 5'h1D;   // e8..ef
   localparam logic [4:0] op5_mov_r_a = 5'h1F;   // f8..ff

   ////////////////////////////////////////
   // sequencer phases

   typedef enum logic [1:0] {
      FETCH,
      OPER1,
      OPER2,
      EXECUTE
   } seq_state_t;

endpackage

// ==== source/uart_pkg.sv ====
package uart_pkg;

   localparam int CLKS_PER_BIT = 16;    // clocks per serial bit
   localparam int FRAME_BITS   = 10;    // start, 8 data, stop
   localparam int LOAD_BYTES   = 256;   // program image size

   // movx addresses of the serial port
   localparam logic [15:0] TX_STATUS_ADDR = 16'h0200;   // bit 0 = busy
   localparam logic [15:0] TX_DATA_ADDR   = 16'h0201;

endpackage

// ==== source/core_bus_if.sv ====
`timescale 1ns/1ps

interface core_bus_if;

   logic           fetch_en;   // sequencer in FETCH
   logic           oper_en;    // OPER1 or OPER2
   logic           exec_en;    // EXECUTE
   isa_pkg::byte_t opcode;
   isa_pkg::byte_t oper1;      // first operand byte
   isa_pkg::byte_t oper2;      // second operand byte

   modport ctrl (
      output fetch_en, oper_en, exec_en,
      output opcode, oper1, oper2
   );

   modport dp (
      input fetch_en, oper_en, exec_en,
      input opcode, oper1, oper2
   );

endinterface

// ==== source/uart_rx_loader.sv ====
`timescale 1ns/1ps

module uart_rx_loader (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_uart_rx,
   input  isa_pkg::code_addr_t i_pc,
   output logic                o_code_wr,
   output isa_pkg::code_addr_t o_code_addr,
   output isa_pkg::byte_t      o_code_data,
   output logic                o_load_done
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t                                 rx_state;
   logic                                      rx_meta;
   logic                                      rx_sync;
   logic [$clog2(uart_pkg::CLKS_PER_BIT)-1:0] tick_cnt;
   logic [2:0]                                bit_idx;
   isa_pkg::byte_t                            shift_q;
   logic [$clog2(uart_pkg::LOAD_BYTES)-1:0]   load_cnt;   // same width as code address
   logic                                      wr_q;
   logic                                      done_q;
   logic                                      half_bit;
   logic                                      full_bit;
   logic                                      byte_end;

   assign half_bit = (tick_cnt == uart_pkg::CLKS_PER_BIT / 2 - 1);
   assign full_bit = (tick_cnt == uart_pkg::CLKS_PER_BIT - 1);
   assign byte_end = (rx_state == RX_STOP) & full_bit;   // mid stop bit

   // two-flop resync, line idles high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_uart_rx;
         rx_sync <= rx_meta;
      end
   end

   ////////////////////////////////////////
   // frame receive

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_state <= RX_IDLE;
         tick_cnt <= '0;
         bit_idx  <= '0;
      end else begin
         tick_cnt <= tick_cnt + 1'b1;
         case (rx_state)
            RX_IDLE: begin
               tick_cnt <= '0;
               if (!rx_sync) rx_state <= RX_START;
            end
            RX_START: if (half_bit) begin
               tick_cnt <= '0;
               bit_idx  <= '0;
               rx_state <= rx_sync ? RX_IDLE : RX_DATA;   // glitch goes back to idle
            end
            RX_DATA: if (full_bit) begin
               tick_cnt <= '0;
               bit_idx  <= bit_idx + 1'b1;
               if (bit_idx == 3'd7) rx_state <= RX_STOP;
            end
            default: if (full_bit) rx_state <= RX_IDLE;
         endcase
      end
   end

   // lsb first
   always_ff @(posedge i_clk) begin
      if (rx_state == RX_DATA && full_bit) shift_q <= {rx_sync, shift_q[7:1]};
   end

   ////////////////////////////////////////
   // load counter and code port

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_q     <= 1'b0;
         done_q   <= 1'b0;
         load_cnt <= '0;
      end else begin
         wr_q <= byte_end & ~done_q;
         if (wr_q) begin
            load_cnt <= load_cnt + 1'b1;
            if (load_cnt == '1) done_q <= 1'b1;   // last byte, count wraps
         end
      end
   end

   assign o_code_wr   = wr_q;
   assign o_code_data = shift_q;
   assign o_code_addr = done_q ? i_pc : load_cnt;
   assign o_load_done = done_q;

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
   input  logic           i_clk,
   input  logic           i_nrst,
   input  logic           i_start,
   input  isa_pkg::byte_t i_data,
   output logic           o_tx,
   output logic           o_busy
);

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_t;

   tx_state_t                                 tx_state;
   logic [$clog2(uart_pkg::CLKS_PER_BIT)-1:0] tick_cnt;
   logic [$clog2(uart_pkg::FRAME_BITS)-1:0]   bit_cnt;
   isa_pkg::byte_t                            shift_q;
   logic                                      bit_end;

   assign bit_end = (tick_cnt == uart_pkg::CLKS_PER_BIT - 1);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         tx_state <= TX_IDLE;
         tick_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         if (tx_state == TX_IDLE || bit_end) tick_cnt <= '0;
         else tick_cnt <= tick_cnt + 1'b1;
         case (tx_state)
            TX_IDLE: begin
               bit_cnt <= '0;
               if (i_start) tx_state <= TX_START;   // start while busy is never seen here
            end
            TX_START: if (bit_end) begin
               tx_state <= TX_SEND;
               bit_cnt  <= 'd1;
            end
            default: if (bit_end) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == uart_pkg::FRAME_BITS - 1) tx_state <= TX_IDLE;   // stop bit done
            end
         endcase
      end
   end

   // ones shift in behind the data, giving the stop bit
   always_ff @(posedge i_clk) begin
      if (tx_state == TX_IDLE && i_start) shift_q <= i_data;
      else if (tx_state == TX_SEND && bit_end) shift_q <= {1'b1, shift_q[7:1]};
   end

   assign o_tx   = (tx_state == TX_IDLE)  ? 1'b1 :
                   (tx_state == TX_START) ? 1'b0 :
                                            shift_q[0];
   assign o_busy = (tx_state != TX_IDLE);

endmodule

// ==== source/seq_ctrl.sv ====
`timescale 1ns/1ps

module seq_ctrl (
   input  logic           i_clk,
   input  logic           i_nrst,
   input  logic           i_load_done,
   input  isa_pkg::byte_t i_code_data,
   core_bus_if.ctrl       bus
);

   isa_pkg::seq_state_t state;
   isa_pkg::seq_state_t state_nxt;
   logic [1:0]          oper_cnt_fetch;   // from the byte on the code bus
   logic [1:0]          oper_cnt_held;    // from the latched opcode

   // operand bytes that follow an opcode
   function automatic logic [1:0] oper_bytes(input isa_pkg::byte_t op);
      logic [1:0] n;
      case (op)
         isa_pkg::op_mov_a_imm, isa_pkg::op_add_a_imm, isa_pkg::op_subb_a_imm,
         isa_pkg::op_xrl_a_imm, isa_pkg::op_sjmp, isa_pkg::op_jz,
         isa_pkg::op_jnz:                         n = 2'd1;
         isa_pkg::op_mov_dptr, isa_pkg::op_ljmp: n = 2'd2;
         default:                                 n = 2'd0;
      endcase
      return n;
   endfunction

   assign oper_cnt_fetch = oper_bytes(i_code_data);
   assign oper_cnt_held  = oper_bytes(bus.opcode);

   always_comb begin
      state_nxt = state;
      case (state)
         isa_pkg::FETCH: if (i_load_done) begin
            state_nxt = (oper_cnt_fetch == 2'd0) ? isa_pkg::EXECUTE : isa_pkg::OPER1;
         end
         isa_pkg::OPER1: state_nxt = (oper_cnt_held == 2'd2) ? isa_pkg::OPER2 : isa_pkg::EXECUTE;
         isa_pkg::OPER2: state_nxt = isa_pkg::EXECUTE;
         default:        state_nxt = isa_pkg::FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) state <= isa_pkg::FETCH;
      else state <= state_nxt;
   end

   // instruction bytes, read at pc in each phase
   always_ff @(posedge i_clk) begin
      if (state == isa_pkg::FETCH && i_load_done) bus.opcode <= i_code_data;
      if (state == isa_pkg::OPER1) bus.oper1 <= i_code_data;
      if (state == isa_pkg::OPER2) bus.oper2 <= i_code_data;
   end

   assign bus.fetch_en = (state == isa_pkg::FETCH);
   assign bus.oper_en  = (state == isa_pkg::OPER1) | (state == isa_pkg::OPER2);
   assign bus.exec_en  = (state == isa_pkg::EXECUTE);

endmodule

// ==== source/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_load_done,
   input  logic                i_acc_zero,
   core_bus_if.dp              bus,
   output isa_pkg::code_addr_t o_pc
);

   logic                step;
   logic                take_rel;
   logic                take_abs;
   isa_pkg::code_addr_t rel_target;

   assign step = (bus.fetch_en & i_load_done) | bus.oper_en;

   // pc already points at the next instruction in EXECUTE
   assign rel_target = o_pc + isa_pkg::code_addr_t'(signed'(bus.oper1));

   assign take_rel = bus.exec_en & ((bus.opcode == isa_pkg::op_sjmp) |
                                    ((bus.opcode == isa_pkg::op_jz)  &  i_acc_zero) |
                                    ((bus.opcode == isa_pkg::op_jnz) & ~i_acc_zero));
   assign take_abs = bus.exec_en & (bus.opcode == isa_pkg::op_ljmp);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_pc <= '0;
      end else if (step) begin
         o_pc <= o_pc + 1'b1;
      end else if (take_rel) begin
         o_pc <= rel_target;
      end else if (take_abs) begin
         o_pc <= bus.oper2;   // low byte of addr16
      end
   end

endmodule

// ==== source/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
   input  logic           i_clk,
   input  logic           i_nrst,
   input  logic           i_tx_busy,
   core_bus_if.dp         bus,
   output logic           o_acc_zero,
   output logic           o_tx_start,
   output isa_pkg::byte_t o_tx_data
);

   isa_pkg::byte_t                         acc;
   isa_pkg::byte_t                         regs [isa_pkg::REG_COUNT];
   logic                                   carry;
   logic [15:0]                            dptr;
   logic [4:0]                             op5;
   logic [$clog2(isa_pkg::REG_COUNT)-1:0]  r_idx;
   isa_pkg::byte_t                         r_sel;
   logic [8:0]                             sub_res;   // bit 8 is the borrow
   isa_pkg::byte_t                         movx_rd;

   assign op5     = bus.opcode[7:3];
   assign r_idx   = bus.opcode[$clog2(isa_pkg::REG_COUNT)-1:0];
   assign r_sel   = regs[r_idx];
   assign sub_res = {1'b0, acc} - {1'b0, bus.oper1} - {8'd0, carry};
   assign movx_rd = (dptr == uart_pkg::TX_STATUS_ADDR) ? {7'd0, i_tx_busy} : 8'd0;

   ////////////////////////////////////////
   // accumulator, carry, dptr

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else if (bus.exec_en) begin
         case (bus.opcode)
            isa_pkg::op_mov_a_imm:   acc <= bus.oper1;
            isa_pkg::op_add_a_imm:   acc <= acc + bus.oper1;   // carry kept
            isa_pkg::op_subb_a_imm: begin
               acc   <= sub_res[7:0];
               carry <= sub_res[8];
            end
            isa_pkg::op_xrl_a_imm:   acc <= acc ^ bus.oper1;
            isa_pkg::op_clr_a:       acc <= '0;
            isa_pkg::op_clr_c:       carry <= 1'b0;
            isa_pkg::op_mov_dptr:    dptr <= {bus.oper1, bus.oper2};
            isa_pkg::op_movx_a_dptr: acc <= movx_rd;
            default: begin
               if (op5 == isa_pkg::op5_mov_a_r) acc <= r_sel;
               else if (op5 == isa_pkg::op5_add_a_r) acc <= acc + r_sel;
            end
         endcase
      end
   end

   // r0..r7
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int i = 0; i < isa_pkg::REG_COUNT; i++) regs[i] <= '0;
      end else if (bus.exec_en) begin
         if (op5 == isa_pkg::op5_mov_r_a) regs[r_idx] <= acc;
         else if (op5 == isa_pkg::op5_inc_r) regs[r_idx] <= r_sel + 1'b1;
      end
   end

   ////////////////////////////////////////
   // outputs

   assign o_acc_zero = (acc == '0);
   assign o_tx_start = bus.exec_en & (bus.opcode == isa_pkg::op_movx_dptr_a) &
                       (dptr == uart_pkg::TX_DATA_ADDR);   // one cycle, EXECUTE only
   assign o_tx_data  = acc;

endmodule

// ==== source/mcu_top.sv ====
`timescale 1ns/1ps

module mcu_top (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_uart_rx,
   output logic                o_uart_tx,
   output logic                o_code_wr,
   output isa_pkg::code_addr_t o_code_addr,
   output isa_pkg::byte_t      o_code_data,
   input  isa_pkg::byte_t      i_code_data
);

   logic                load_done;
   isa_pkg::code_addr_t pc;
   logic                acc_zero;
   logic                tx_start;
   isa_pkg::byte_t      tx_data;
   logic                tx_busy;

   core_bus_if bus ();

   ////////////////////////////////////////
   // program load and serial out

   uart_rx_loader u_loader (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .i_pc        (pc),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_code_data (o_code_data),
      .o_load_done (load_done)
   );

   uart_tx u_tx (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_start(tx_start),
      .i_data (tx_data),
      .o_tx   (o_uart_tx),
      .o_busy (tx_busy)
   );

   ////////////////////////////////////////
   // core

   seq_ctrl u_seq (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_code_data (i_code_data),
      .bus         (bus)
   );

   pc_unit u_pc (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_acc_zero  (acc_zero),
      .bus         (bus),
      .o_pc        (pc)
   );

   exec_unit u_exec (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_tx_busy  (tx_busy),
      .bus        (bus),
      .o_acc_zero (acc_zero),
      .o_tx_start (tx_start),
      .o_tx_data  (tx_data)
   );

endmodule

// ==== test/mcu_assert.sv ====
`timescale 1ns/1ps

module mcu_assert (
   input logic i_clk,
   input logic i_nrst,
   input logic i_load_done,
   input logic i_fetch_en,
   input logic i_oper_en,
   input logic i_exec_en,
   input logic i_start,
   input logic i_busy
);

   // sequencer stays in FETCH while the program loads
   hold_fetch: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_load_done |=> i_fetch_en)
      else $error("sequencer left FETCH before the load was complete");

   // a fetch after the load hands over to exactly one later phase
   fetch_advance: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_load_done && i_fetch_en |=> !i_fetch_en && $onehot({i_oper_en, i_exec_en}))
      else $error("sequencer did not move to one operand or execute phase after FETCH");

   start_idle: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_busy |-> !i_start)
      else $error("transmit start seen while the transmitter was busy");

endmodule

bind seq_ctrl mcu_assert u_seq_chk (
   .i_clk       (i_clk),
   .i_nrst      (i_nrst),
   .i_load_done (i_load_done),
   .i_fetch_en  (bus.fetch_en),
   .i_oper_en   (bus.oper_en),
   .i_exec_en   (bus.exec_en),
   .i_start     (1'b0),
   .i_busy      (1'b0)
);

// only the start/busy check is live here
bind uart_tx mcu_assert u_tx_chk (
   .i_clk       (i_clk),
   .i_nrst      (i_nrst),
   .i_load_done (1'b0),
   .i_fetch_en  (1'b1),
   .i_oper_en   (1'b0),
   .i_exec_en   (1'b0),
   .i_start     (i_start),
   .i_busy      (o_busy)
);

// ==== test/mcu_tb.sv ====
`timescale 1ns/1ps

module mcu_tb;

   logic                clk;
   logic                nrst;
   logic                uart_rx;
   logic                uart_tx;
   logic                code_wr;
   isa_pkg::code_addr_t code_addr;
   isa_pkg::byte_t      code_wdata;
   isa_pkg::byte_t      code_rdata;

   integer         seed;
   isa_pkg::byte_t image [uart_pkg::LOAD_BYTES];      // program as sent on the serial line
   isa_pkg::byte_t code_mem [uart_pkg::LOAD_BYTES];   // external code memory
   int             prog_len;
   isa_pkg::byte_t exp_q [$];                         // predicted transmit bytes
   string          name_q [$];
   int             exp_total;
   isa_pkg::byte_t m_acc;                             // instruction model
   isa_pkg::byte_t m_regs [isa_pkg::REG_COUNT];
   logic           m_carry;
   int             errors;
   int             wr_count;
   int             rx_frames;
   logic           first_stop;                        // first frame is in its stop bit

   mcu_top DUT (
      .i_clk       (clk),
      .i_nrst      (nrst),
      .i_uart_rx   (uart_rx),
      .o_uart_tx   (uart_tx),
      .o_code_wr   (code_wr),
      .o_code_addr (code_addr),
      .o_code_data (code_wdata),
      .i_code_data (code_rdata)
   );

   assign code_rdata = code_mem[code_addr];   // combinational read

   always #4 clk = ~clk;

   always @(posedge clk) begin
      if (code_wr) code_mem[code_addr] <= code_wdata;
   end

   ////////////////////////////////////////
   // program builder and model

   task automatic emit_byte(input isa_pkg::byte_t b);
      image[prog_len] = b;
      prog_len++;
   endtask

   // save A, poll busy, send, restore A
   task automatic emit_send(input string name);
      emit_byte({isa_pkg::op5_mov_r_a, 3'd7});
      emit_byte(isa_pkg::op_mov_dptr);
      emit_byte(uart_pkg::TX_STATUS_ADDR[15:8]);
      emit_byte(uart_pkg::TX_STATUS_ADDR[7:0]);
      emit_byte(isa_pkg::op_movx_a_dptr);
      emit_byte(isa_pkg::op_jnz);
      emit_byte(8'hFD);   // back to the movx
      emit_byte(isa_pkg::op_mov_dptr);
      emit_byte(uart_pkg::TX_DATA_ADDR[15:8]);
      emit_byte(uart_pkg::TX_DATA_ADDR[7:0]);
      emit_byte({isa_pkg::op5_mov_a_r, 3'd7});
      emit_byte(isa_pkg::op_movx_dptr_a);
      m_regs[7] = m_acc;
      exp_q.push_back(m_acc);
      name_q.push_back(name);
   endtask

   task automatic emit_alu();
      int             kind;
      int             diff;
      isa_pkg::byte_t imm;
      logic [2:0]     rn;
      kind = $unsigned($random(seed)) % 10;
      imm  = isa_pkg::byte_t'($random(seed));
      rn   = 3'($random(seed));
      case (kind)
         0: emit_byte(isa_pkg::op_mov_a_imm);
         1: emit_byte(isa_pkg::op_add_a_imm);
         2: emit_byte(isa_pkg::op_subb_a_imm);
         3: emit_byte(isa_pkg::op_xrl_a_imm);
         4: emit_byte(isa_pkg::op_clr_a);
         5: emit_byte(isa_pkg::op_clr_c);
         6: emit_byte({isa_pkg::op5_mov_r_a, rn});
         7: emit_byte({isa_pkg::op5_mov_a_r, rn});
         8: emit_byte({isa_pkg::op5_add_a_r, rn});
         default: emit_byte({isa_pkg::op5_inc_r, rn});
      endcase
      if (kind < 4) emit_byte(imm);   // immediate forms
      case (kind)
         0: m_acc = imm;
         1: m_acc = m_acc + imm;      // carry untouched
         2: begin
            diff    = int'(m_acc) - int'(imm) - int'(m_carry);
            m_carry = (diff < 0);
            m_acc   = isa_pkg::byte_t'(diff);
         end
         3: m_acc = m_acc ^ imm;
         4: m_acc = 8'h00;
         5: m_carry = 1'b0;
         6: m_regs[rn] = m_acc;
         7: m_acc = m_regs[rn];
         8: m_acc = m_acc + m_regs[rn];
         default: m_regs[rn] = m_regs[rn] + 8'd1;
      endcase
   endtask

   task automatic build_program();
      logic use_jz;
      logic taken;
      prog_len = 0;
      m_acc    = 8'h00;
      m_carry  = 1'b0;
      for (int i = 0; i < uart_pkg::LOAD_BYTES; i++) image[i] = 8'h00;
      for (int i = 0; i < isa_pkg::REG_COUNT; i++) m_regs[i] = 8'h00;
      emit_byte(isa_pkg::op_ljmp);        // lands on address 5
      emit_byte(8'h00);
      emit_byte(8'h05);
      emit_byte(isa_pkg::op_mov_a_imm);   // jumped over, would spoil A
      emit_byte(8'h5A);
      for (int i = 0; i < 12; i++) begin
         emit_alu();
         emit_send("alu");
      end
      if ($random(seed) & 1) begin
         emit_byte(isa_pkg::op_clr_a);
         m_acc = 8'h00;
      end
      use_jz = $random(seed) & 1;
      emit_byte(use_jz ? isa_pkg::op_jz : isa_pkg::op_jnz);
      emit_byte(8'h04);
      emit_byte(isa_pkg::op_mov_a_imm);   // not taken
      emit_byte(8'h11);
      emit_byte(isa_pkg::op_sjmp);
      emit_byte(8'h02);
      emit_byte(isa_pkg::op_mov_a_imm);   // taken
      emit_byte(8'h22);
      taken = use_jz ? (m_acc == 8'h00) : (m_acc != 8'h00);
      m_acc = taken ? 8'h22 : 8'h11;
      emit_send("marker");
      emit_byte(isa_pkg::op_sjmp);        // park here
      emit_byte(8'hFE);
      exp_total = exp_q.size();
   endtask

   ////////////////////////////////////////
   // serial driver and monitor

   task automatic send_serial(input isa_pkg::byte_t b);
      uart_rx <= 1'b0;
      repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);
      for (int i = 0; i < 8; i++) begin
         uart_rx <= b[i];   // lsb first
         repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);
      end
      uart_rx    <= 1'b1;
      first_stop <= 1'b1;
      repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);
   endtask

   initial begin : tx_monitor
      isa_pkg::byte_t d;
      isa_pkg::byte_t expv;
      string          nm;
      forever begin
         @(negedge clk);
         if (nrst && !uart_tx) begin
            repeat (uart_pkg::CLKS_PER_BIT / 2 - 1) @(negedge clk);   // mid start bit
            assert (!uart_tx) else begin
               errors++;
               $display("ERROR frame_start: expected 0, actual %b", uart_tx);
            end
            for (int i = 0; i < 8; i++) begin
               repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
               d[i] = uart_tx;
            end
            repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
            assert (uart_tx) else begin
               errors++;
               $display("ERROR frame_stop: expected 1, actual %b", uart_tx);
            end
            assert (exp_q.size() != 0) else begin
               errors++;
               $display("unexpected frame %02h after the last predicted send", d);
            end
            if (exp_q.size() != 0) begin
               expv = exp_q.pop_front();
               nm   = name_q.pop_front();
               assert (d == expv) else begin
                  errors++;
                  $display("ERROR %s frame %0d: expected %02h, actual %02h", nm, rx_frames,
                           expv, d);
               end
            end
            rx_frames++;
         end
      end
   end

   ////////////////////////////////////////
   // load checks

   always @(negedge clk) begin
      if (nrst && wr_count < uart_pkg::LOAD_BYTES) begin
         assert (uart_tx) else begin
            errors++;
            $display("ERROR idle_tx: expected 1, actual %b", uart_tx);
         end
      end
      if (nrst && !first_stop) begin
         assert (!code_wr) else begin
            errors++;
            $display("ERROR early_write: expected 0, actual %b", code_wr);
         end
      end
      if (code_wr) begin
         assert (wr_count < uart_pkg::LOAD_BYTES) else begin
            errors++;
            $display("code memory was written after the load had finished");
         end
         if (wr_count < uart_pkg::LOAD_BYTES) begin
            assert (code_addr == isa_pkg::code_addr_t'(wr_count)) else begin
               errors++;
               $display("ERROR load_addr: expected %02h, actual %02h", wr_count, code_addr);
            end
            assert (code_wdata == image[wr_count]) else begin
               errors++;
               $display("ERROR load_data at %02h: expected %02h, actual %02h", wr_count,
                        image[wr_count], code_wdata);
            end
         end
         wr_count++;
      end
   end

   initial begin : watchdog
      repeat ((uart_pkg::LOAD_BYTES + 20) * uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT * 2)
         @(posedge clk);
      $display("timeout: %0d of %0d frames, %0d code writes, %0d errors", rx_frames,
               exp_total, wr_count, errors);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      clk        = 1'b0;
      nrst       = 1'b0;
      uart_rx    = 1'b1;
      first_stop = 1'b0;
      errors     = 0;
      wr_count   = 0;
      rx_frames  = 0;
      seed       = 32'h3bb3;
      for (int i = 0; i < uart_pkg::LOAD_BYTES; i++) begin
         code_mem[i] <= isa_pkg::byte_t'(i) ^ 8'hA5;
      end
      build_program();
      repeat (4) @(posedge clk);
      nrst <= 1'b1;
      repeat (4) @(posedge clk);
      for (int i = 0; i < uart_pkg::LOAD_BYTES; i++) send_serial(image[i]);
      while (rx_frames < exp_total) @(posedge clk);
      // quiet window, the park loop must not send
      repeat (3 * uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT) @(posedge clk);
      assert (wr_count == uart_pkg::LOAD_BYTES) else begin
         errors++;
         $display("ERROR load_count: expected %0d, actual %0d", uart_pkg::LOAD_BYTES, wr_count);
      end
      assert (rx_frames == exp_total) else begin
         errors++;
         $display("ERROR frame_count: expected %0d, actual %0d", exp_total, rx_frames);
      end
      $display("errors: %0d, frames: %0d of %0d, code writes: %0d", errors, rx_frames,
               exp_total, wr_count);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== list.f ====
source/isa_pkg.sv
source/uart_pkg.sv
source/core_bus_if.sv
source/uart_rx_loader.sv
source/uart_tx.sv
source/seq_ctrl.sv
source/pc_unit.sv
source/exec_unit.sv
source/mcu_top.sv
test/mcu_assert.sv
test/mcu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal \
   --top-module mcu_tb \
   -f list.f \
   -o sim_mcu

# output goes to the console through stderr, grep decides the status
./obj_dir/sim_mcu | tee /dev/stderr | grep -qx "NO ERRORS"
